/* Bender.yml */
package:
  name: rob

sources:
  - hw/rob_cfg_pkg.sv
  - hw/rob_types_pkg.sv
  - hw/cdb_if.sv
  - hw/rob_queue.sv
  - hw/rob_ctrl.sv
  - hw/cdb_writeback.sv
  - hw/commit_order.sv
  - hw/retire_rat.sv
  - hw/rob_top.sv
  - target: test
    files:
      - tests/rob_tb.sv

/* hw/cdb_if.sv */
interface cdb_if;

    // One-cycle completion pulses, one per lane
    logic                   valid   [rob_cfg_pkg::SS];
    rob_cfg_pkg::rob_id_t   rob_id  [rob_cfg_pkg::SS];
    // Result tag travels with the bus
    rob_cfg_pkg::phys_reg_t phys_rd [rob_cfg_pkg::SS];

    modport source (
        output valid,
        output rob_id,
        output phys_rd
    );

    modport sink (
        input valid,
        input rob_id,
        input phys_rd
    );

endinterface

/* hw/cdb_writeback.sv */
module cdb_writeback (
    input  logic                 clk,
    input  logic                 rst,
    cdb_if.sink                  cdb,
    input  rob_cfg_pkg::rob_id_t head,
    input  rob_cfg_pkg::rob_id_t tail,
    output logic                 mark_en [rob_cfg_pkg::SS],
    output rob_cfg_pkg::rob_id_t mark_id [rob_cfg_pkg::SS]
);

    rob_cfg_pkg::rob_id_t head_q;
    rob_cfg_pkg::rob_id_t tail_q;
    logic                 full_q;
    logic                 full_now;
    logic                 head_moved;
    logic                 tail_moved;
    rob_cfg_pkg::rob_id_t used;
    rob_cfg_pkg::rob_id_t offset [rob_cfg_pkg::SS];

    // head == tail is ambiguous, so track which pointer caught up with the other
    assign head_moved = (head != head_q);
    assign tail_moved = (tail != tail_q);

    always_comb begin
        if (tail_moved && !head_moved) begin
            full_now = (head == tail);
        end else if (head_moved && !tail_moved) begin
            full_now = 1'b0;
        end else begin
            full_now = full_q;
        end
    end

    assign used = tail - head;

    // Pass a lane through only if it names an occupied slot
    always_comb begin
        for (int i = 0; i < rob_cfg_pkg::SS; i++) begin
            offset[i]  = cdb.rob_id[i] - head;
            mark_id[i] = cdb.rob_id[i];
            mark_en[i] = cdb.valid[i] && (full_now || (offset[i] < used));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head_q <= '0;
            tail_q <= '0;
            full_q <= 1'b0;
        end else begin
            head_q <= head;
            tail_q <= tail;
            full_q <= full_now;
        end
    end

endmodule

/* hw/commit_order.sv */
module commit_order (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      pop,
    input  rob_types_pkg::rob_entry_t head_entry     [rob_cfg_pkg::SS],
    output logic                      commit_valid,
    output rob_cfg_pkg::pc_t          commit_pc      [rob_cfg_pkg::SS],
    output rob_cfg_pkg::arch_reg_t    commit_arch_rd [rob_cfg_pkg::SS],
    output rob_cfg_pkg::phys_reg_t    commit_phys_rd [rob_cfg_pkg::SS],
    output rob_cfg_pkg::order_t       commit_order   [rob_cfg_pkg::SS]
);

    // Order number of the next instruction to retire
    rob_cfg_pkg::order_t order_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            commit_valid <= 1'b0;
            order_cnt    <= '0;
        end else begin
            commit_valid <= pop;
            if (pop) begin
                order_cnt <= order_cnt + rob_cfg_pkg::order_t'(rob_cfg_pkg::SS);
            end
        end
    end

    // Lane 0 is older, so it takes the lower number
    always_ff @(posedge clk) begin
        if (pop) begin
            for (int i = 0; i < rob_cfg_pkg::SS; i++) begin
                commit_pc[i]      <= head_entry[i].pc;
                commit_arch_rd[i] <= head_entry[i].arch_rd;
                commit_phys_rd[i] <= head_entry[i].phys_rd;
                commit_order[i]   <= order_cnt + rob_cfg_pkg::order_t'(i);
            end
        end
    end

endmodule

/* hw/retire_rat.sv */
module retire_rat (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      pop,
    input  rob_types_pkg::rob_entry_t head_entry [rob_cfg_pkg::SS],
    input  rob_cfg_pkg::arch_reg_t    rrat_arch,
    output rob_cfg_pkg::phys_reg_t    rrat_phys
);

    rob_cfg_pkg::phys_reg_t rat_map [rob_cfg_pkg::ARCH_REG_COUNT];

    always_ff @(posedge clk) begin
        if (rst) begin
            // Identity map out of reset
            for (int r = 0; r < rob_cfg_pkg::ARCH_REG_COUNT; r++) begin
                rat_map[r] <= rob_cfg_pkg::phys_reg_t'(r);
            end
        end else if (pop) begin
            // Later lane overrides an earlier one on the same register
            for (int i = 0; i < rob_cfg_pkg::SS; i++) begin
                if (head_entry[i].has_rd && (head_entry[i].arch_rd != '0)) begin
                    rat_map[head_entry[i].arch_rd] <= head_entry[i].phys_rd;
                end
            end
        end
    end

    assign rrat_phys = rat_map[rrat_arch];

endmodule

/* hw/rob_cfg_pkg.sv */
package rob_cfg_pkg;

    // Superscalar width for dispatch and retirement
    localparam int SS = 2;

    localparam int ROB_DEPTH = 8;
    localparam int ROB_ID_W  = $clog2(ROB_DEPTH);
    // Occupancy must be able to hold ROB_DEPTH itself
    localparam int ROB_CNT_W = $clog2(ROB_DEPTH + 1);

    localparam int ARCH_REG_COUNT = 32;
    localparam int PHYS_REG_COUNT = 64;
    localparam int ARCH_REG_W     = $clog2(ARCH_REG_COUNT);
    localparam int PHYS_REG_W     = $clog2(PHYS_REG_COUNT);

    localparam int ORDER_W = 64;
    localparam int PC_W    = 32;

    typedef logic [ROB_ID_W-1:0]   rob_id_t;
    typedef logic [ROB_CNT_W-1:0]  rob_cnt_t;
    typedef logic [ARCH_REG_W-1:0] arch_reg_t;
    typedef logic [PHYS_REG_W-1:0] phys_reg_t;
    typedef logic [ORDER_W-1:0]    order_t;
    typedef logic [PC_W-1:0]       pc_t;

endpackage

/* hw/rob_ctrl.sv */
module rob_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      dispatch_req,
    output logic                      dispatch_ack,
    output rob_cfg_pkg::rob_id_t      dispatch_rob_id [rob_cfg_pkg::SS],
    output logic                      push,
    output rob_cfg_pkg::rob_id_t      tail,
    output rob_cfg_pkg::rob_id_t      head,
    input  rob_types_pkg::rob_entry_t head_entry [rob_cfg_pkg::SS],
    output logic                      pop
);

    rob_types_pkg::disp_state_t state;
    rob_types_pkg::disp_state_t state_next;
    rob_cfg_pkg::rob_cnt_t      count;
    rob_cfg_pkg::rob_cnt_t      free_slots;
    logic                       space_ok;

    assign free_slots = rob_cfg_pkg::rob_cnt_t'(rob_cfg_pkg::ROB_DEPTH) - count;
    assign space_ok   = free_slots >= rob_cfg_pkg::rob_cnt_t'(rob_cfg_pkg::SS);

    // A whole pair is taken at once, or the request waits
    assign push         = (state == rob_types_pkg::IDLE) && dispatch_req && space_ok;
    assign dispatch_ack = (state != rob_types_pkg::IDLE);

    // Retire only when every lane of the head group is complete
    always_comb begin
        pop = (count != '0);
        for (int i = 0; i < rob_cfg_pkg::SS; i++) begin
            pop &= head_entry[i].done;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            rob_types_pkg::IDLE: begin
                if (push) begin
                    state_next = rob_types_pkg::ACK;
                end
            end
            rob_types_pkg::ACK: begin
                state_next = dispatch_req ? rob_types_pkg::WAIT_LOW : rob_types_pkg::IDLE;
            end
            rob_types_pkg::WAIT_LOW: begin
                if (!dispatch_req) begin
                    state_next = rob_types_pkg::IDLE;
                end
            end
            default: state_next = rob_types_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= rob_types_pkg::IDLE;
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            state <= state_next;
            if (push) begin
                tail <= tail + rob_cfg_pkg::rob_id_t'(rob_cfg_pkg::SS);
            end
            if (pop) begin
                head <= head + rob_cfg_pkg::rob_id_t'(rob_cfg_pkg::SS);
            end
            if (push && !pop) begin
                count <= count + rob_cfg_pkg::rob_cnt_t'(rob_cfg_pkg::SS);
            end else if (pop && !push) begin
                count <= count - rob_cfg_pkg::rob_cnt_t'(rob_cfg_pkg::SS);
            end
        end
    end

    // Ids are captured at the push and held through the ack phase
    always_ff @(posedge clk) begin
        if (push) begin
            for (int i = 0; i < rob_cfg_pkg::SS; i++) begin
                dispatch_rob_id[i] <= tail + rob_cfg_pkg::rob_id_t'(i);
            end
        end
    end

endmodule

/* hw/rob_queue.sv */
module rob_queue (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      push,
    input  rob_cfg_pkg::rob_id_t      tail,
    input  rob_types_pkg::rob_entry_t push_entry [rob_cfg_pkg::SS],
    input  logic                      mark_en    [rob_cfg_pkg::SS],
    input  rob_cfg_pkg::rob_id_t      mark_id    [rob_cfg_pkg::SS],
    input  rob_cfg_pkg::rob_id_t      head,
    output rob_types_pkg::rob_entry_t head_entry [rob_cfg_pkg::SS]
);

    rob_types_pkg::rob_entry_t          entries [rob_cfg_pkg::ROB_DEPTH];
    logic [rob_cfg_pkg::ROB_DEPTH-1:0] done_q;
    rob_cfg_pkg::rob_id_t               wr_idx  [rob_cfg_pkg::SS];
    rob_cfg_pkg::rob_id_t               rd_idx  [rob_cfg_pkg::SS];

    // Slot indices wrap through the natural overflow of rob_id_t
    always_comb begin
        for (int i = 0; i < rob_cfg_pkg::SS; i++) begin
            wr_idx[i] = tail + rob_cfg_pkg::rob_id_t'(i);
            rd_idx[i] = head + rob_cfg_pkg::rob_id_t'(i);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            for (int i = 0; i < rob_cfg_pkg::SS; i++) begin
                entries[wr_idx[i]] <= push_entry[i];
            end
        end
    end

    // Done flags live apart from the payload so completion can set them
    always_ff @(posedge clk) begin
        if (rst) begin
            done_q <= '0;
        end else begin
            if (push) begin
                for (int i = 0; i < rob_cfg_pkg::SS; i++) begin
                    done_q[wr_idx[i]] <= 1'b0;
                end
            end
            // Marks only target occupied slots, so they never collide with a push
            for (int i = 0; i < rob_cfg_pkg::SS; i++) begin
                if (mark_en[i]) begin
                    done_q[mark_id[i]] <= 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < rob_cfg_pkg::SS; i++) begin
            head_entry[i]      = entries[rd_idx[i]];
            head_entry[i].done = done_q[rd_idx[i]];
        end
    end

endmodule

/* hw/rob_top.sv */
module rob_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   dispatch_req,
    input  rob_cfg_pkg::pc_t       disp_pc         [rob_cfg_pkg::SS],
    input  rob_cfg_pkg::arch_reg_t disp_arch_rd    [rob_cfg_pkg::SS],
    input  rob_cfg_pkg::phys_reg_t disp_phys_rd    [rob_cfg_pkg::SS],
    input  logic                   disp_has_rd     [rob_cfg_pkg::SS],
    output logic                   dispatch_ack,
    output rob_cfg_pkg::rob_id_t   dispatch_rob_id [rob_cfg_pkg::SS],
    input  logic                   cdb_valid       [rob_cfg_pkg::SS],
    input  rob_cfg_pkg::rob_id_t   cdb_rob_id      [rob_cfg_pkg::SS],
    output logic                   commit_valid,
    output rob_cfg_pkg::pc_t       commit_pc       [rob_cfg_pkg::SS],
    output rob_cfg_pkg::arch_reg_t commit_arch_rd  [rob_cfg_pkg::SS],
    output rob_cfg_pkg::phys_reg_t commit_phys_rd  [rob_cfg_pkg::SS],
    output rob_cfg_pkg::order_t    commit_order    [rob_cfg_pkg::SS],
    input  rob_cfg_pkg::arch_reg_t rrat_arch,
    output rob_cfg_pkg::phys_reg_t rrat_phys
);

    logic                      push;
    logic                      pop;
    rob_cfg_pkg::rob_id_t      head;
    rob_cfg_pkg::rob_id_t      tail;
    rob_types_pkg::rob_entry_t push_entry [rob_cfg_pkg::SS];
    rob_types_pkg::rob_entry_t head_entry [rob_cfg_pkg::SS];
    logic                      mark_en    [rob_cfg_pkg::SS];
    rob_cfg_pkg::rob_id_t      mark_id    [rob_cfg_pkg::SS];

    cdb_if cdb_bus ();

    assign cdb_bus.valid  = cdb_valid;
    assign cdb_bus.rob_id = cdb_rob_id;
    // Result tags are not tracked by the ROB
    assign cdb_bus.phys_rd = '{default: '0};

    for (genvar i = 0; i < rob_cfg_pkg::SS; i++) begin : g_push_entry
        assign push_entry[i] = '{
            pc:      disp_pc[i],
            arch_rd: disp_arch_rd[i],
            phys_rd: disp_phys_rd[i],
            has_rd:  disp_has_rd[i],
            done:    1'b0
        };
    end

    rob_ctrl rob_ctrl_inst (
        .clk             (clk),
        .rst             (rst),
        .dispatch_req    (dispatch_req),
        .dispatch_ack    (dispatch_ack),
        .dispatch_rob_id (dispatch_rob_id),
        .push            (push),
        .tail            (tail),
        .head            (head),
        .head_entry      (head_entry),
        .pop             (pop)
    );

    rob_queue rob_queue_inst (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .tail       (tail),
        .push_entry (push_entry),
        .mark_en    (mark_en),
        .mark_id    (mark_id),
        .head       (head),
        .head_entry (head_entry)
    );

    cdb_writeback cdb_writeback_inst (
        .clk     (clk),
        .rst     (rst),
        .cdb     (cdb_bus.sink),
        .head    (head),
        .tail    (tail),
        .mark_en (mark_en),
        .mark_id (mark_id)
    );

    commit_order commit_order_inst (
        .clk            (clk),
        .rst            (rst),
        .pop            (pop),
        .head_entry     (head_entry),
        .commit_valid   (commit_valid),
        .commit_pc      (commit_pc),
        .commit_arch_rd (commit_arch_rd),
        .commit_phys_rd (commit_phys_rd),
        .commit_order   (commit_order)
    );

    retire_rat retire_rat_inst (
        .clk        (clk),
        .rst        (rst),
        .pop        (pop),
        .head_entry (head_entry),
        .rrat_arch  (rrat_arch),
        .rrat_phys  (rrat_phys)
    );

endmodule

/* hw/rob_types_pkg.sv */
package rob_types_pkg;

    // One ROB slot, 45 bits wide
    typedef struct packed {
        rob_cfg_pkg::pc_t       pc;
        rob_cfg_pkg::arch_reg_t arch_rd;
        rob_cfg_pkg::phys_reg_t phys_rd;
        logic                   has_rd;
        // Set once the CDB reports completion
        logic                   done;
    } rob_entry_t;

    // Dispatch handshake phases
    // ACK is the first cycle after a push, WAIT_LOW holds ack until req drops
    typedef enum logic [1:0] {
        IDLE,
        ACK,
        WAIT_LOW
    } disp_state_t;

endpackage

/* tb.f */
hw/rob_cfg_pkg.sv
hw/rob_types_pkg.sv
hw/cdb_if.sv
hw/rob_queue.sv
hw/rob_ctrl.sv
hw/cdb_writeback.sv
hw/commit_order.sv
hw/retire_rat.sv
hw/rob_top.sv
tests/rob_tb.sv

/* tests/rob_tb.sv */
module rob_tb;

    localparam int WAIT_LIMIT = 50;
    localparam int NUM_STEPS  = 17;

    localparam logic [1:0] OP_DISP  = 2'd0;
    localparam logic [1:0] OP_HOLD  = 2'd1;
    localparam logic [1:0] OP_DRAIN = 2'd2;
    localparam logic [1:0] OP_RRAT  = 2'd3;

    // Lane 1 pc is lane 0 pc plus 4
    typedef struct packed {
        logic [1:0]             op;
        rob_cfg_pkg::pc_t       pc;
        rob_cfg_pkg::arch_reg_t arch0;
        rob_cfg_pkg::phys_reg_t phys0;
        logic                   has0;
        rob_cfg_pkg::arch_reg_t arch1;
        rob_cfg_pkg::phys_reg_t phys1;
        logic                   has1;
    } step_t;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   dispatch_req;
    rob_cfg_pkg::pc_t       disp_pc         [rob_cfg_pkg::SS];
    rob_cfg_pkg::arch_reg_t disp_arch_rd    [rob_cfg_pkg::SS];
    rob_cfg_pkg::phys_reg_t disp_phys_rd    [rob_cfg_pkg::SS];
    logic                   disp_has_rd     [rob_cfg_pkg::SS];
    logic                   dispatch_ack;
    rob_cfg_pkg::rob_id_t   dispatch_rob_id [rob_cfg_pkg::SS];
    logic                   cdb_valid       [rob_cfg_pkg::SS];
    rob_cfg_pkg::rob_id_t   cdb_rob_id      [rob_cfg_pkg::SS];
    logic                   commit_valid;
    rob_cfg_pkg::pc_t       commit_pc       [rob_cfg_pkg::SS];
    rob_cfg_pkg::arch_reg_t commit_arch_rd  [rob_cfg_pkg::SS];
    rob_cfg_pkg::phys_reg_t commit_phys_rd  [rob_cfg_pkg::SS];
    rob_cfg_pkg::order_t    commit_order    [rob_cfg_pkg::SS];
    rob_cfg_pkg::arch_reg_t rrat_arch;
    rob_cfg_pkg::phys_reg_t rrat_phys;

    // Reference model of the queue, the order counter and the RRAT
    rob_cfg_pkg::pc_t       m_pc   [rob_cfg_pkg::ROB_DEPTH];
    rob_cfg_pkg::arch_reg_t m_arch [rob_cfg_pkg::ROB_DEPTH];
    rob_cfg_pkg::phys_reg_t m_phys [rob_cfg_pkg::ROB_DEPTH];
    bit                     m_has  [rob_cfg_pkg::ROB_DEPTH];
    bit                     m_done [rob_cfg_pkg::ROB_DEPTH];
    rob_cfg_pkg::phys_reg_t m_rat  [rob_cfg_pkg::ARCH_REG_COUNT];
    rob_cfg_pkg::order_t    m_order;
    int                     m_head;
    int                     m_tail;
    int                     m_count;

    // Twelve dispatched pairs take the ids three times around the 8 entries
    step_t steps [NUM_STEPS] = '{
        '{OP_DISP,  32'h1000, 5'd1,  6'd33, 1'b1, 5'd2,  6'd34, 1'b1},
        '{OP_DISP,  32'h1008, 5'd3,  6'd35, 1'b1, 5'd5,  6'd36, 1'b1},
        '{OP_DISP,  32'h1010, 5'd5,  6'd40, 1'b1, 5'd5,  6'd41, 1'b1},
        '{OP_DISP,  32'h1018, 5'd7,  6'd50, 1'b0, 5'd0,  6'd51, 1'b1},
        '{OP_HOLD,  32'h1020, 5'd8,  6'd42, 1'b1, 5'd9,  6'd43, 1'b1},
        '{OP_DRAIN, 32'h0,    5'd0,  6'd0,  1'b0, 5'd0,  6'd0,  1'b0},
        '{OP_RRAT,  32'h0,    5'd0,  6'd0,  1'b0, 5'd0,  6'd0,  1'b0},
        '{OP_DISP,  32'h1028, 5'd1,  6'd44, 1'b1, 5'd10, 6'd45, 1'b1},
        '{OP_DISP,  32'h1030, 5'd12, 6'd46, 1'b1, 5'd1,  6'd47, 1'b1},
        '{OP_DISP,  32'h1038, 5'd31, 6'd60, 1'b1, 5'd2,  6'd61, 1'b0},
        '{OP_DISP,  32'h1040, 5'd3,  6'd62, 1'b1, 5'd3,  6'd63, 1'b1},
        '{OP_DRAIN, 32'h0,    5'd0,  6'd0,  1'b0, 5'd0,  6'd0,  1'b0},
        '{OP_DISP,  32'h1048, 5'd4,  6'd20, 1'b1, 5'd6,  6'd21, 1'b1},
        '{OP_DISP,  32'h1050, 5'd5,  6'd22, 1'b1, 5'd0,  6'd23, 1'b0},
        '{OP_DISP,  32'h1058, 5'd2,  6'd24, 1'b1, 5'd11, 6'd25, 1'b1},
        '{OP_DRAIN, 32'h0,    5'd0,  6'd0,  1'b0, 5'd0,  6'd0,  1'b0},
        '{OP_RRAT,  32'h0,    5'd0,  6'd0,  1'b0, 5'd0,  6'd0,  1'b0}
    };

    rob_top rob_top_inst (
        .clk             (clk),
        .rst             (rst),
        .dispatch_req    (dispatch_req),
        .disp_pc         (disp_pc),
        .disp_arch_rd    (disp_arch_rd),
        .disp_phys_rd    (disp_phys_rd),
        .disp_has_rd     (disp_has_rd),
        .dispatch_ack    (dispatch_ack),
        .dispatch_rob_id (dispatch_rob_id),
        .cdb_valid       (cdb_valid),
        .cdb_rob_id      (cdb_rob_id),
        .commit_valid    (commit_valid),
        .commit_pc       (commit_pc),
        .commit_arch_rd  (commit_arch_rd),
        .commit_phys_rd  (commit_phys_rd),
        .commit_order    (commit_order),
        .rrat_arch       (rrat_arch),
        .rrat_phys       (rrat_phys)
    );

    always #2 clk = ~clk;

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            $display("mismatch at time %0t: %s is %0h, expected %0h",
                     $time, name, got, expected);
            $display("Verification failed");
            $fatal(1, "stopped at the first error");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at time %0t while waiting for %s", $time, what);
        $display("Verification failed");
        $fatal(1, "stopped on a timeout");
    endtask

    function automatic bit head_ready();
        return (m_count > 0) && m_done[m_head]
            && m_done[(m_head + 1) % rob_cfg_pkg::ROB_DEPTH];
    endfunction

    // Compare the registered commit pair and retire it in the model
    task automatic retire_pair();
        int id;
        for (int i = 0; i < rob_cfg_pkg::SS; i++) begin
            id = (m_head + i) % rob_cfg_pkg::ROB_DEPTH;
            check_value($sformatf("commit_pc[%0d]", i), commit_pc[i], m_pc[id]);
            check_value($sformatf("commit_arch_rd[%0d]", i), commit_arch_rd[i], m_arch[id]);
            check_value($sformatf("commit_phys_rd[%0d]", i), commit_phys_rd[i], m_phys[id]);
            check_value($sformatf("commit_order[%0d]", i), commit_order[i], m_order + i);
            // Lane 1 is applied last, so it wins on a shared register
            if (m_has[id] && m_arch[id] != '0) begin
                m_rat[m_arch[id]] = m_phys[id];
            end
        end
        m_order = m_order + rob_cfg_pkg::SS;
        m_head  = (m_head + rob_cfg_pkg::SS) % rob_cfg_pkg::ROB_DEPTH;
        m_count = m_count - rob_cfg_pkg::SS;
    endtask

    // One CDB pulse on a random lane, then every retirement it unlocks
    task automatic complete_entry(input int id);
        int lane;
        int n;
        lane = $urandom % rob_cfg_pkg::SS;
        cdb_valid[lane]  <= 1'b1;
        cdb_rob_id[lane] <= rob_cfg_pkg::rob_id_t'(id);
        @(posedge clk);
        cdb_valid[lane] <= 1'b0;
        m_done[id] = 1'b1;
        if (head_ready()) begin
            n = 0;
            do begin
                @(posedge clk);
                n++;
            end while (!commit_valid && n < WAIT_LIMIT);
            if (!commit_valid) begin
                report_timeout("commit_valid after the last completion of the head pair");
            end
            check_value("commit latency in edges", n, 2);
            retire_pair();
            // Pairs that completed earlier follow one edge apart
            while (head_ready()) begin
                @(posedge clk);
                check_value("commit_valid", commit_valid, 1);
                retire_pair();
            end
            @(posedge clk);
            check_value("commit_valid", commit_valid, 0);
        end
    endtask

    task automatic complete_all();
        int ids [$];
        int id;
        int j;
        int tmp;
        for (int k = 0; k < m_count; k++) begin
            id = (m_head + k) % rob_cfg_pkg::ROB_DEPTH;
            if (!m_done[id]) begin
                ids.push_back(id);
            end
        end
        for (int k = ids.size() - 1; k > 0; k--) begin
            j      = $urandom % (k + 1);
            tmp    = ids[k];
            ids[k] = ids[j];
            ids[j] = tmp;
        end
        foreach (ids[k]) begin
            complete_entry(ids[k]);
        end
    endtask

    task automatic start_dispatch(input step_t s);
        dispatch_req    <= 1'b1;
        disp_pc[0]      <= s.pc;
        disp_pc[1]      <= s.pc + 32'd4;
        disp_arch_rd[0] <= s.arch0;
        disp_arch_rd[1] <= s.arch1;
        disp_phys_rd[0] <= s.phys0;
        disp_phys_rd[1] <= s.phys1;
        disp_has_rd[0]  <= s.has0;
        disp_has_rd[1]  <= s.has1;
    endtask

    task automatic finish_dispatch(input step_t s);
        int n;
        int id1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!dispatch_ack && n < WAIT_LIMIT);
        if (!dispatch_ack) begin
            report_timeout("dispatch_ack to rise");
        end
        for (int i = 0; i < rob_cfg_pkg::SS; i++) begin
            check_value($sformatf("dispatch_rob_id[%0d]", i), dispatch_rob_id[i],
                        (m_tail + i) % rob_cfg_pkg::ROB_DEPTH);
        end
        id1 = (m_tail + 1) % rob_cfg_pkg::ROB_DEPTH;
        m_pc[m_tail]   = s.pc;
        m_arch[m_tail] = s.arch0;
        m_phys[m_tail] = s.phys0;
        m_has[m_tail]  = s.has0;
        m_done[m_tail] = 1'b0;
        m_pc[id1]      = s.pc + 32'd4;
        m_arch[id1]    = s.arch1;
        m_phys[id1]    = s.phys1;
        m_has[id1]     = s.has1;
        m_done[id1]    = 1'b0;
        m_tail  = (m_tail + rob_cfg_pkg::SS) % rob_cfg_pkg::ROB_DEPTH;
        m_count = m_count + rob_cfg_pkg::SS;
        dispatch_req <= 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (dispatch_ack && n < WAIT_LIMIT);
        if (dispatch_ack) begin
            report_timeout("dispatch_ack to fall");
        end
    endtask

    // With the ROB full, ack waits until the head pair retires
    task automatic dispatch_when_full(input step_t s);
        int first;
        start_dispatch(s);
        repeat (4) begin
            @(posedge clk);
            check_value("dispatch_ack", dispatch_ack, 0);
        end
        first = $urandom % rob_cfg_pkg::SS;
        complete_entry((m_head + first) % rob_cfg_pkg::ROB_DEPTH);
        complete_entry((m_head + 1 - first) % rob_cfg_pkg::ROB_DEPTH);
        finish_dispatch(s);
    endtask

    task automatic sweep_rrat();
        for (int r = 0; r < rob_cfg_pkg::ARCH_REG_COUNT; r++) begin
            rrat_arch <= rob_cfg_pkg::arch_reg_t'(r);
            @(posedge clk);
            check_value($sformatf("rrat_phys for r%0d", r), rrat_phys, m_rat[r]);
            check_value("dispatch_ack", dispatch_ack, 0);
            check_value("commit_valid", commit_valid, 0);
        end
    endtask

    initial begin
        void'($urandom(15));
        rst          = 1'b1;
        dispatch_req = 1'b0;
        rrat_arch    = '0;
        for (int i = 0; i < rob_cfg_pkg::SS; i++) begin
            disp_pc[i]      = '0;
            disp_arch_rd[i] = '0;
            disp_phys_rd[i] = '0;
            disp_has_rd[i]  = 1'b0;
            cdb_valid[i]    = 1'b0;
            cdb_rob_id[i]   = '0;
        end
        m_head  = 0;
        m_tail  = 0;
        m_count = 0;
        m_order = '0;
        for (int r = 0; r < rob_cfg_pkg::ARCH_REG_COUNT; r++) begin
            m_rat[r] = rob_cfg_pkg::phys_reg_t'(r);
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        // Identity map and idle outputs right after reset
        sweep_rrat();
        foreach (steps[s]) begin
            case (steps[s].op)
                OP_DISP: begin
                    start_dispatch(steps[s]);
                    finish_dispatch(steps[s]);
                end
                OP_HOLD:  dispatch_when_full(steps[s]);
                OP_DRAIN: complete_all();
                default:  sweep_rrat();
            endcase
        end
        $display("Verification passed");
        $finish;
    end

endmodule
